/* src/mem_pkg.sv */
// Shared types for the CPU memory subsystem.
// Import into any module that speaks the word-RAM or APB bus.
package mem_pkg;

    localparam int ADDR_W = 24; // Byte address space.
    localparam int WORD_W = 16; // RAM word width.

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    typedef enum logic {
        op_read,
        op_write
    } mem_op_e;

    // Request from a peer to the word RAM. Bit 0 of addr is ignored.
    typedef struct packed {
        logic       valid;
        mem_op_e    op;
        addr_t      addr;
        word_t      wdata;
        logic [1:0] wstrb; // Bit 0 enables the low byte.
    } mem_req_t;

    typedef struct packed {
        logic  gnt;
        word_t rdata;      // Valid in the granted cycle of a read.
    } mem_rsp_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        addr_t      paddr;
        word_t      pwdata;
        logic [1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        apb_idle,
        apb_wait_gnt,
        apb_done
    } apb_state_e;

endpackage

/* src/word_ram.sv */
// 16-bit word RAM on the arbitrated port.
// Reads are combinational, writes happen at the clock edge with byte strobes.
`timescale 1ns/1ps

module word_ram import mem_pkg::*; #(
    parameter int RAM_AW = 12   // Word address bits.
) (
    input  logic     clk,
    input  mem_req_t ram_req,
    output word_t    ram_rdata
);

    localparam int DEPTH = 2 ** RAM_AW;

    word_t             mem [DEPTH];
    logic [RAM_AW-1:0] waddr;
    logic              we;

    // Byte address bit 0 dropped, upper bits wrap.
    assign waddr = ram_req.addr[RAM_AW:1];
    assign we    = ram_req.valid && (ram_req.op == op_write);

    assign ram_rdata = mem[waddr];

    always_ff @(posedge clk) begin
        if (we) begin
            if (ram_req.wstrb[0]) mem[waddr][7:0]  <= ram_req.wdata[7:0];
            if (ram_req.wstrb[1]) mem[waddr][15:8] <= ram_req.wdata[15:8];
        end
    end

endmodule

/* src/mem_arbiter.sv */
// Round-robin arbiter between the fetch window (port 0) and the APB port (port 1).
// Grants combinationally and moves the pointer past each winner.
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t req0,
    input  mem_req_t req1,
    output mem_rsp_t rsp0,
    output mem_rsp_t rsp1,
    output mem_req_t ram_req,
    input  word_t    ram_rdata
);

    logic ptr;          // Preferred port when both ask.
    logic gnt0;
    logic gnt1;

    assign gnt0 = req0.valid && (!req1.valid || !ptr);
    assign gnt1 = req1.valid && (!req0.valid || ptr);

    always_comb begin
        ram_req       = gnt1 ? req1 : req0;
        ram_req.valid = gnt0 || gnt1;   // No write without a winner.
    end

    // Read data goes to both and only the winner sees gnt.
    assign rsp0.gnt   = gnt0;
    assign rsp0.rdata = ram_rdata;
    assign rsp1.gnt   = gnt1;
    assign rsp1.rdata = ram_rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= 1'b0;
        end else if (gnt0) begin
            ptr <= 1'b1;
        end else if (gnt1) begin
            ptr <= 1'b0;
        end
    end

    a_one_gnt: assert property (
        @(posedge clk) disable iff (rst)
        !(rsp0.gnt && rsp1.gnt)
    ) else $error("both RAM peers granted in one cycle");

    // A losing fetch request wins on the next cycle.
    a_fetch_wait: assert property (
        @(posedge clk) disable iff (rst)
        req0.valid && !rsp0.gnt |=> !req0.valid || rsp0.gnt
    ) else $error("fetch request waited more than one cycle");

endmodule

/* src/apb_mem_port.sv */
// APB slave port for host access to the word RAM.
// Each access phase becomes one RAM request, pready follows the grant by a cycle.
`timescale 1ns/1ps

module apb_mem_port import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    apb_state_e state;
    word_t      rdata_q;    // Read data held for the host.
    logic       access;

    assign access = apb_req.psel && apb_req.penable;

    // Request straight from the host signals, they are held until pready.
    always_comb begin
        mem_req.valid = access && (state != apb_done);
        mem_req.op    = apb_req.pwrite ? op_write : op_read;
        mem_req.addr  = apb_req.paddr;
        mem_req.wdata = apb_req.pwdata;
        mem_req.wstrb = apb_req.pstrb;
    end

    assign apb_rsp.pready = (state == apb_done);
    assign apb_rsp.prdata = rdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= apb_idle;
        end else begin
            case (state)
                apb_idle: begin
                    if (access) state <= mem_rsp.gnt ? apb_done : apb_wait_gnt;
                end
                apb_wait_gnt: begin
                    if (mem_rsp.gnt) state <= apb_done;  // Lost arbitration before.
                end
                default: state <= apb_idle;          // pready is up for one cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_rsp.gnt) rdata_q <= mem_rsp.rdata;
    end

    a_penable_psel: assert property (
        @(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel
    ) else $error("APB penable high without psel");

endmodule

/* src/fetch_window.sv */
// Four-byte prefetch window for the CPU core.
// Follows pc, or idx_addr while ldram_en is high, and refills from the word RAM.
`timescale 1ns/1ps

module fetch_window import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ldram_en,
    input  addr_t       idx_addr,
    input  addr_t       pc,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp,
    output logic [31:0] fetch_data,
    output logic        fetch_rdy
);

    addr_t           base;      // Address of byte 0 in the window.
    logic [3:0][7:0] win;       // Cached bytes, byte 0 lowest.
    logic [3:0]      vld;       // Byte holds good data.
    logic [3:0]      pend;      // Byte still has to be read.
    addr_t           sel_addr;
    addr_t           step;
    logic [1:0]      shift_n;   // Byte offset of a forward step or 0 for a reload.
    logic [3:0]      keep;
    logic            do_move;
    logic [3:0]      fill_hit;
    logic [3:0][7:0] fill_byte;

    // Index of the lowest byte that still waits for data.
    function automatic logic [1:0] first_pend(input logic [3:0] m);
        logic [1:0] idx;
        idx = 2'd3;
        for (int k = 3; k >= 0; k--) begin
            if (m[k]) idx = 2'(k);
        end
        return idx;
    endfunction

    assign sel_addr   = ldram_en ? idx_addr : pc;
    assign fetch_rdy  = (&vld) && (base == sel_addr);
    assign fetch_data = win;        // Little endian with the lowest byte at sel_addr.

    // New window only once the current fill is over.
    assign do_move = (pend == 4'b0000) && !fetch_rdy;
    assign step    = sel_addr - base;

    always_comb begin
        shift_n = 2'd0;
        if ((&vld) && step >= addr_t'(1) && step <= addr_t'(3)) begin
            shift_n = step[1:0];    // Overlap with the old window.
        end
        keep = (shift_n == 2'd0) ? 4'b0000 : (4'b1111 >> shift_n);
    end

    // One word read per grant aimed at the lowest pending byte.
    always_comb begin
        mem_req       = '0;
        mem_req.valid = |pend;
        mem_req.op    = op_read;
        mem_req.addr  = base + ADDR_W'(first_pend(pend));
    end

    // Every pending byte that lives in the returned word is taken.
    always_comb begin
        addr_t a;
        for (int j = 0; j < 4; j++) begin
            a            = base + ADDR_W'(j);
            fill_byte[j] = a[0] ? mem_rsp.rdata[15:8] : mem_rsp.rdata[7:0];
            fill_hit[j]  = pend[j] && mem_rsp.gnt &&
                           (a[ADDR_W-1:1] == mem_req.addr[ADDR_W-1:1]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base <= '0;
            vld  <= 4'b0000;
            pend <= 4'b0000;
        end else if (do_move) begin
            base <= sel_addr;
            vld  <= keep;
            pend <= ~keep;          // Missing bytes only.
        end else if (|fill_hit) begin
            vld  <= vld | fill_hit;
            pend <= pend & ~fill_hit;
        end
    end

    // Byte storage slides down on a move and fills per grant.
    always_ff @(posedge clk) begin
        if (do_move) begin
            win <= win >> {shift_n, 3'b000}; // Slide kept bytes down.
        end else begin
            for (int j = 0; j < 4; j++) begin
                if (fill_hit[j]) win[j] <= fill_byte[j];
            end
        end
    end

    // A waiting request must not move before the arbiter takes it.
    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        mem_req.valid && !mem_rsp.gnt |=> $stable(mem_req.addr)
    ) else $error("fetch request address changed while waiting for grant");

endmodule

/* src/mem_sys_top.sv */
// Memory subsystem top: fetch window and APB port sharing one word RAM.
// Set RAM_AW here for the RAM depth.
`timescale 1ns/1ps

module mem_sys_top import mem_pkg::*; #(
    parameter int RAM_AW = 12
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ldram_en,
    input  addr_t       idx_addr,
    input  addr_t       pc,
    output logic [31:0] fetch_data,
    output logic        fetch_rdy,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp
);

    mem_req_t fw_req;       // Port 0.
    mem_rsp_t fw_rsp;
    mem_req_t apb_mreq;     // Port 1.
    mem_rsp_t apb_mrsp;
    mem_req_t ram_req;
    word_t    ram_rdata;

    fetch_window u_fetch_window (
        .clk        (clk),
        .rst        (rst),
        .ldram_en   (ldram_en),
        .idx_addr   (idx_addr),
        .pc         (pc),
        .mem_req    (fw_req),
        .mem_rsp    (fw_rsp),
        .fetch_data (fetch_data),
        .fetch_rdy  (fetch_rdy)
    );

    apb_mem_port u_apb_mem_port (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .mem_req (apb_mreq),
        .mem_rsp (apb_mrsp)
    );

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .rst       (rst),
        .req0      (fw_req),
        .req1      (apb_mreq),
        .rsp0      (fw_rsp),
        .rsp1      (apb_mrsp),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    word_ram #(
        .RAM_AW (RAM_AW)
    ) u_word_ram (
        .clk       (clk),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

endmodule

/* verification/mem_sys_tb.sv */
// Testbench for the memory subsystem, driven by command lines from the golden file.
// Run from the project root so the golden file path resolves.
`timescale 1ns/1ps

module mem_sys_tb import mem_pkg::*; ();

    localparam int TIMEOUT = 200;   // Cycles allowed for any wait.

    logic        clk;
    logic        rst;
    logic        ldram_en;
    addr_t       idx_addr;
    addr_t       pc;
    logic [31:0] fetch_data;
    logic        fetch_rdy;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    logic [31:0] lfsr;      // Idle gap generator state.
    int          pass_cnt;
    int          fail_cnt;
    int          test_err;  // Errors seen in the running test.
    bit          stalled;   // A wait ran out, the run stops.

    mem_sys_top #(
        .RAM_AW (12)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .ldram_en   (ldram_en),
        .idx_addr   (idx_addr),
        .pc         (pc),
        .fetch_data (fetch_data),
        .fetch_rdy  (fetch_rdy),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period.
    end

    // Fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic idle_gap();
        logic [1:0] n;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            n[b] = lfsr[0];         // One step per bit.
        end
        repeat (n) @(posedge clk);
    endtask

    // Inputs change 2 ns after the rising edge.
    task automatic next_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic check_word(input addr_t a, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %0t: read at %h expected %h got %h", $time, a, exp, act);
            test_err++;
        end
    endtask

    task automatic check_fetch(input addr_t a, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0t: fetch at %h expected %h got %h", $time, a, exp, act);
            test_err++;
        end
    endtask

    // One APB transfer, setup then access until pready.
    task automatic apb_xfer(input logic wr, input addr_t a, input word_t d,
                            input logic [1:0] s, output word_t rd);
        int n;
        next_drive_slot();
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = a;
        apb_req.pwdata  = d;
        apb_req.pstrb   = s;
        next_drive_slot();
        apb_req.penable = 1'b1;     // Access phase.
        for (n = 0; n < TIMEOUT && !apb_rsp.pready; n++) @(negedge clk);
        rd = apb_rsp.prdata;        // Sampled mid cycle.
        if (!apb_rsp.pready) begin
            $display("timeout: pready never rose for the APB access at %h", a);
            stalled = 1'b1;
            test_err++;
        end
        next_drive_slot();
        apb_req = '0;
    endtask

    // Point the window at a new address and wait for fetch_rdy.
    task automatic fetch_check(input logic sel, input addr_t a, input logic [31:0] exp);
        int n;
        next_drive_slot();
        ldram_en = sel;
        if (sel) idx_addr = a;
        else pc = a;
        @(negedge clk);
        for (n = 0; n < TIMEOUT && !fetch_rdy; n++) @(negedge clk);
        if (fetch_rdy) begin
            check_fetch(a, exp, fetch_data);
        end else begin
            $display("timeout: fetch_rdy never rose for the fetch at %h", a);
            stalled = 1'b1;
            test_err++;
        end
    endtask

    task automatic close_test(input int num, input string what);
        if (test_err == 0) begin
            pass_cnt++;
            $display("test %0d %s ok", num, what);
        end else begin
            fail_cnt++;
            $display("test %0d %s failed with %0d errors", num, what, test_err);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          c;
        int          tnum;
        logic [7:0]  cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        word_t       rd;
        rst      = 1'b1;
        ldram_en = 1'b0;
        idx_addr = '0;
        pc       = '0;
        apb_req  = '0;
        lfsr     = 32'h306a;
        pass_cnt = 0;
        fail_cnt = 0;
        stalled  = 1'b0;
        tnum     = 1;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        test_err = 0;               // Outputs still at reset values here.
        if (fetch_rdy !== 1'b0 || apb_rsp.pready !== 1'b0) begin
            $display("ERR %0t: fetch_rdy %b pready %b after reset", $time,
                     fetch_rdy, apb_rsp.pready);
            test_err++;
        end
        close_test(0, "reset state");
        fd = $fopen("verification/mem_sys_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            fail_cnt++;
        end
        while (fd != 0 && !stalled) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) break;
            if (cmd == "#") begin
                c = 0;
                while (c != "\n" && c != -1) c = $fgetc(fd); // Skip comment line.
                continue;
            end
            test_err = 0;
            case (cmd)
                "W": begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    apb_xfer(1'b1, addr_t'(f1), word_t'(f2), f3[1:0], rd);
                    close_test(tnum, $sformatf("write %h", f1[23:0]));
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", f1, f2);
                    apb_xfer(1'b0, addr_t'(f1), '0, 2'b00, rd);
                    if (!stalled) check_word(addr_t'(f1), word_t'(f2), rd);
                    close_test(tnum, $sformatf("read %h", f1[23:0]));
                end
                "F": begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    fetch_check(f1[0], addr_t'(f2), f3);
                    close_test(tnum, $sformatf("fetch sel %0d at %h", f1[0], f2[23:0]));
                end
                "B": begin
                    code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    fork                    // Both peers contend for the RAM.
                        fetch_check(1'b0, addr_t'(f1), f2);
                        begin
                            apb_xfer(1'b0, addr_t'(f3), '0, 2'b00, rd);
                            if (!stalled) check_word(addr_t'(f3), word_t'(f4), rd);
                        end
                    join
                    close_test(tnum, $sformatf("fetch %h with read %h", f1[23:0], f3[23:0]));
                end
                default: begin
                    $display("unknown command %c in the golden file", cmd);
                    test_err++;
                    close_test(tnum, "bad command");
                end
            endcase
            tnum++;
            idle_gap();
        end
        if (fd != 0) $fclose(fd);
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !stalled) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verification/mem_sys_golden.txt */
# W addr data strb | R addr expected | F sel addr expected32 | B faddr fexp32 raddr rexp
# All fields hex. sel 1 fetches through idx_addr, sel 0 through pc. B fetches via pc.
W 000100 2211 3
W 000102 4433 3
W 000104 6655 3
W 000106 8877 3
W 000108 aa99 3
W 00010a ccbb 3
W 00010c eedd 3
W 00010e 00ff 3
W 000200 b0a0 3
W 000202 d0c0 3
W 000204 f0e0 3
W 000206 1101 3
# Byte strobes keep the other byte.
W 000300 1234 3
W 000300 abcd 1
W 000302 5678 3
W 000302 ef00 2
R 000100 2211
R 00010e 00ff
R 000204 f0e0
R 000300 12cd
R 000302 ef78
# Even and odd refills, then steps of 1, 2, 3 and a backward jump.
F 0 000100 44332211
F 0 000105 99887766
F 0 000106 aa998877
F 0 000108 ccbbaa99
F 0 00010b ffeeddcc
F 0 000102 66554433
F 0 000103 77665544
F 0 000106 aa998877
F 0 000109 ddccbbaa
# Indexed fetches, back to pc and over again.
F 1 000200 d0c0b0a0
F 1 000203 01f0e0d0
F 1 000201 e0d0c0b0
F 0 000104 88776655
F 1 000202 f0e0d0c0
F 0 000101 55443322
# Fetches with APB reads at the same time.
B 000100 44332211 000200 b0a0
B 000107 bbaa9988 000202 d0c0
B 00010a eeddccbb 000300 12cd
B 000101 55443322 000302 ef78
B 000104 88776655 000100 2211
B 000102 66554433 000206 1101

/* build.f */
src/mem_pkg.sv
src/word_ram.sv
src/mem_arbiter.sv
src/apb_mem_port.sv
src/fetch_window.sv
src/mem_sys_top.sv
verification/mem_sys_tb.sv

/* Bender.yml */
package:
  name: mem_sys

sources:
  - files:
      - src/mem_pkg.sv
      - src/word_ram.sv
      - src/mem_arbiter.sv
      - src/apb_mem_port.sv
      - src/fetch_window.sv
      - src/mem_sys_top.sv
  - target: test
    files:
      - verification/mem_sys_tb.sv
